// ==== accel_consts.svh ====
`ifndef ACCEL_CONSTS_SVH
`define ACCEL_CONSTS_SVH

// register bus.
`define ACCEL_IO_DATA_WIDTH 32
`define ACCEL_IO_ADDR_WIDTH 9

// scanner bank.
`define ACCEL_CHAN_COUNT 4
`define ACCEL_CHAN_BITS 2

// toeplitz hash engine.
`define ACCEL_HASH_WIDTH 32
`define ACCEL_HASH_MAX_BYTES 36

// the key covers ACCEL_HASH_MAX_BYTES bytes plus one hash-width window.
`define ACCEL_HASH_KEY \
  320'h6d5a56da255b0ec24167253d43a38fb0d0ca2bcbae7b30b477cb2da38030f20c6a42b73bbeac01fa

`endif

// ==== accel_pkg.sv ====
package accel_pkg;

  // hash engine command, one pulse per bus write to the hash region.
  typedef enum logic [2:0] {
    HASH_NONE  = 3'd0,
    HASH_CLEAR = 3'd1,
    HASH_ADD1  = 3'd2,
    HASH_ADD2  = 3'd3,
    HASH_ADD4  = 3'd4
  } hash_op_e;

  typedef enum logic [2:0] {
    CMD_NONE      = 3'd0,
    CMD_INIT      = 3'd1,
    CMD_STOP      = 3'd2,
    CMD_PATTERN   = 3'd3,
    CMD_DATA      = 3'd4,
    CMD_DATA_LAST = 3'd5 // the word ends the packet.
  } chan_cmd_e;

  typedef enum logic {
    SCAN_IDLE = 1'b0,
    SCAN_FEED = 1'b1 // bytes of a data word are being consumed.
  } scan_state_e;

endpackage

// ==== scan_channel.sv ====
`include "accel_consts.svh"

module scan_channel (
  input  logic                            clk,
  input  logic                            rst,
  input  accel_pkg::chan_cmd_e            chan_cmd,
  input  logic [`ACCEL_IO_DATA_WIDTH-1:0] cmd_word,
  output logic                            busy,
  output logic                            overrun,
  output logic                            done,
  output logic                            match,
  output logic [`ACCEL_IO_DATA_WIDTH-1:0] pattern
);

  accel_pkg::scan_state_e state;

  logic [1:0] bytes_left;
  logic [2:0] seen;
  logic [2:0] seen_next;
  logic       last_word;

  logic [`ACCEL_IO_DATA_WIDTH-1:0] shift_reg;
  logic [`ACCEL_IO_DATA_WIDTH-1:0] history;
  logic [`ACCEL_IO_DATA_WIDTH-1:0] history_next;
  logic [`ACCEL_IO_DATA_WIDTH-1:0] pattern_reg;
  logic                            match_hit;

  assign busy    = (state == accel_pkg::SCAN_FEED);
  assign pattern = pattern_reg;

  // the newest byte enters at the bottom, so the oldest sits in the top byte.
  assign history_next = {history[23:0], shift_reg[31:24]};
  assign seen_next    = (seen == 3'd4) ? seen : seen + 3'd1;
  assign match_hit    = (seen_next == 3'd4) && (history_next == pattern_reg);

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= accel_pkg::SCAN_IDLE;
      bytes_left <= 2'd0;
      seen       <= 3'd0;
      overrun    <= 1'b0;
      done       <= 1'b0;
      match      <= 1'b0;
    end else begin
      if (state == accel_pkg::SCAN_FEED) begin
        seen       <= seen_next;
        bytes_left <= bytes_left - 2'd1;
        if (match_hit) begin
          match <= 1'b1;
        end
        if (bytes_left == 2'd0) begin
          state <= accel_pkg::SCAN_IDLE;
          if (last_word) begin
            done <= 1'b1;
          end
        end
      end

      case (chan_cmd)
        accel_pkg::CMD_INIT: begin
          state   <= accel_pkg::SCAN_IDLE;
          seen    <= 3'd0;
          overrun <= 1'b0;
          done    <= 1'b0;
          match   <= 1'b0;
        end
        accel_pkg::CMD_STOP: begin
          state <= accel_pkg::SCAN_IDLE; // abandons the rest of the word.
          done  <= 1'b1;
        end
        accel_pkg::CMD_DATA, accel_pkg::CMD_DATA_LAST: begin
          if (state == accel_pkg::SCAN_FEED) begin
            overrun <= 1'b1; // the word is dropped.
          end else begin
            state      <= accel_pkg::SCAN_FEED;
            bytes_left <= 2'd3;
          end
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == accel_pkg::SCAN_FEED) begin
      history   <= history_next;
      shift_reg <= {shift_reg[23:0], 8'h00};
    end

    case (chan_cmd)
      accel_pkg::CMD_INIT: begin
        history <= '0;
      end
      accel_pkg::CMD_PATTERN: begin
        pattern_reg <= cmd_word;
      end
      accel_pkg::CMD_DATA, accel_pkg::CMD_DATA_LAST: begin
        if (state == accel_pkg::SCAN_IDLE) begin
          shift_reg <= cmd_word;
          last_word <= (chan_cmd == accel_pkg::CMD_DATA_LAST);
        end
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== toeplitz_hash.sv ====
`include "accel_consts.svh"

module toeplitz_hash (
  input  logic                            clk,
  input  logic                            rst,
  input  accel_pkg::hash_op_e             hash_op,
  input  logic [`ACCEL_IO_DATA_WIDTH-1:0] hash_word,
  output logic [`ACCEL_HASH_WIDTH-1:0]    hash_out
);

  localparam int HW       = `ACCEL_HASH_WIDTH;
  localparam int MAX      = `ACCEL_HASH_MAX_BYTES;
  localparam int KEY_BITS = MAX * 8 + HW;

  localparam logic [KEY_BITS-1:0] KEY = `ACCEL_HASH_KEY;

  logic [5:0]    offset; // byte offset into the key.
  logic [5:0]    offset_sum;
  logic [2:0]    add_bytes;
  logic [HW-1:0] hash_next;

  always_comb begin
    case (hash_op)
      accel_pkg::HASH_ADD1: add_bytes = 3'd1;
      accel_pkg::HASH_ADD2: add_bytes = 3'd2;
      accel_pkg::HASH_ADD4: add_bytes = 3'd4;
      default:              add_bytes = 3'd0;
    endcase
  end

  assign offset_sum = offset + {3'b000, add_bytes};

  // every set input bit folds in the key window that starts at its global bit position.
  always_comb begin
    hash_next = hash_out;
    for (int i = 0; i < 4; i++) begin
      if ((i < int'(add_bytes)) && (int'(offset) + i < MAX)) begin
        for (int j = 0; j < 8; j++) begin
          if (hash_word[31 - 8 * i - j]) begin
            hash_next = hash_next ^ KEY[KEY_BITS - 1 - ((int'(offset) + i) * 8 + j) -: HW];
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hash_out <= '0;
      offset   <= 6'd0;
    end else begin
      case (hash_op)
        accel_pkg::HASH_CLEAR: begin
          hash_out <= '0;
          offset   <= 6'd0;
        end
        accel_pkg::HASH_ADD1, accel_pkg::HASH_ADD2, accel_pkg::HASH_ADD4: begin
          hash_out <= hash_next;
          offset   <= (offset_sum > 6'(MAX)) ? 6'(MAX) : offset_sum; // holds at the key end.
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// ==== accel_regs.sv ====
`include "accel_consts.svh"

module accel_regs (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            io_en,
  input  logic                            io_wen,
  input  logic [`ACCEL_IO_ADDR_WIDTH-1:0] io_addr,
  input  logic [`ACCEL_IO_DATA_WIDTH-1:0] io_wr_data,
  output logic [`ACCEL_IO_DATA_WIDTH-1:0] io_rd_data,
  output logic                            io_rd_valid,

  output accel_pkg::chan_cmd_e            chan_cmd [`ACCEL_CHAN_COUNT],
  output logic [`ACCEL_IO_DATA_WIDTH-1:0] cmd_word,
  input  logic [`ACCEL_CHAN_COUNT-1:0]    chan_busy,
  input  logic [`ACCEL_CHAN_COUNT-1:0]    chan_overrun,
  input  logic [`ACCEL_CHAN_COUNT-1:0]    chan_done,
  input  logic [`ACCEL_CHAN_COUNT-1:0]    chan_match,
  input  logic [`ACCEL_IO_DATA_WIDTH-1:0] chan_pattern [`ACCEL_CHAN_COUNT],

  output accel_pkg::hash_op_e             hash_op,
  output logic [`ACCEL_IO_DATA_WIDTH-1:0] hash_word,
  input  logic [`ACCEL_HASH_WIDTH-1:0]    hash_out
);

  logic [`ACCEL_CHAN_BITS-1:0]     chan_idx;
  logic                            chan_hit;
  logic                            wr_req;
  logic                            rd_req;
  logic                            rd_stall;
  logic                            stall_reg;
  logic [`ACCEL_IO_DATA_WIDTH-1:0] rd_mux;

  assign wr_req   = io_en && io_wen;
  assign rd_req   = io_en && !io_wen;
  assign chan_idx = io_addr[4 +: `ACCEL_CHAN_BITS];
  assign chan_hit = (io_addr[6:4] < 3'(`ACCEL_CHAN_COUNT));

  // a hash read that meets a pending opcode waits for the engine to update.
  assign rd_stall = rd_req && io_addr[8] && (hash_op != accel_pkg::HASH_NONE);

  always_comb begin
    rd_mux = '0;
    if (io_addr[8]) begin
      rd_mux[`ACCEL_HASH_WIDTH-1:0] = hash_out;
    end else if (io_addr[7]) begin
      rd_mux[`ACCEL_CHAN_COUNT-1:0] = chan_done | chan_match;
    end else if (chan_hit) begin
      case (io_addr[3:2])
        2'd0: begin
          rd_mux[1] = chan_busy[chan_idx];
          rd_mux[2] = chan_overrun[chan_idx];
          rd_mux[8] = chan_done[chan_idx];
          rd_mux[9] = chan_match[chan_idx];
        end
        2'd1: begin
          rd_mux = chan_pattern[chan_idx];
        end
        default: begin
        end
      endcase
    end
  end

  // command pulses last one cycle.
  always_ff @(posedge clk) begin
    if (rst) begin
      foreach (chan_cmd[i]) begin
        chan_cmd[i] <= accel_pkg::CMD_NONE;
      end
      hash_op <= accel_pkg::HASH_NONE;
    end else begin
      foreach (chan_cmd[i]) begin
        chan_cmd[i] <= accel_pkg::CMD_NONE;
      end
      hash_op <= accel_pkg::HASH_NONE;
      if (wr_req) begin
        if (io_addr[8]) begin
          case (io_addr[7:2])
            6'h00:   hash_op <= accel_pkg::HASH_CLEAR;
            6'h01:   hash_op <= accel_pkg::HASH_ADD1;
            6'h02:   hash_op <= accel_pkg::HASH_ADD2;
            6'h03:   hash_op <= accel_pkg::HASH_ADD4;
            default: hash_op <= accel_pkg::HASH_NONE;
          endcase
        end else if (!io_addr[7] && chan_hit) begin
          case (io_addr[3:2])
            2'd0: begin
              if (io_wr_data[0]) begin
                chan_cmd[chan_idx] <= accel_pkg::CMD_INIT;
              end else if (io_wr_data[4]) begin
                chan_cmd[chan_idx] <= accel_pkg::CMD_STOP;
              end
            end
            2'd1:    chan_cmd[chan_idx] <= accel_pkg::CMD_PATTERN;
            2'd2:    chan_cmd[chan_idx] <= accel_pkg::CMD_DATA;
            default: chan_cmd[chan_idx] <= accel_pkg::CMD_DATA_LAST;
          endcase
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_req && io_addr[8]) begin
      hash_word <= io_wr_data;
    end
    if (wr_req && !io_addr[8] && !io_addr[7]) begin
      cmd_word <= io_wr_data; // shared by all channels.
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      io_rd_valid <= 1'b0;
      stall_reg   <= 1'b0;
    end else begin
      io_rd_valid <= (rd_req && !rd_stall) || stall_reg;
      stall_reg   <= rd_stall;
    end
  end

  always_ff @(posedge clk) begin
    if (stall_reg) begin
      io_rd_data <= '0;
      io_rd_data[`ACCEL_HASH_WIDTH-1:0] <= hash_out;
    end else if (rd_req) begin
      io_rd_data <= rd_mux;
    end
  end

endmodule

// ==== accel_top.sv ====
`include "accel_consts.svh"

module accel_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            io_en,
  input  logic                            io_wen,
  input  logic [`ACCEL_IO_ADDR_WIDTH-1:0] io_addr,
  input  logic [`ACCEL_IO_DATA_WIDTH-1:0] io_wr_data,
  output logic [`ACCEL_IO_DATA_WIDTH-1:0] io_rd_data,
  output logic                            io_rd_valid
);

  accel_pkg::chan_cmd_e            chan_cmd [`ACCEL_CHAN_COUNT];
  logic [`ACCEL_IO_DATA_WIDTH-1:0] cmd_word;
  logic [`ACCEL_CHAN_COUNT-1:0]    chan_busy;
  logic [`ACCEL_CHAN_COUNT-1:0]    chan_overrun;
  logic [`ACCEL_CHAN_COUNT-1:0]    chan_done;
  logic [`ACCEL_CHAN_COUNT-1:0]    chan_match;
  logic [`ACCEL_IO_DATA_WIDTH-1:0] chan_pattern [`ACCEL_CHAN_COUNT];

  accel_pkg::hash_op_e             hash_op;
  logic [`ACCEL_IO_DATA_WIDTH-1:0] hash_word;
  logic [`ACCEL_HASH_WIDTH-1:0]    hash_out;

  accel_regs i_regs (
    .clk          (clk),
    .rst          (rst),
    .io_en        (io_en),
    .io_wen       (io_wen),
    .io_addr      (io_addr),
    .io_wr_data   (io_wr_data),
    .io_rd_data   (io_rd_data),
    .io_rd_valid  (io_rd_valid),
    .chan_cmd     (chan_cmd),
    .cmd_word     (cmd_word),
    .chan_busy    (chan_busy),
    .chan_overrun (chan_overrun),
    .chan_done    (chan_done),
    .chan_match   (chan_match),
    .chan_pattern (chan_pattern),
    .hash_op      (hash_op),
    .hash_word    (hash_word),
    .hash_out     (hash_out)
  );

  for (genvar n = 0; n < `ACCEL_CHAN_COUNT; n++) begin : g_chan
    scan_channel i_chan (
      .clk      (clk),
      .rst      (rst),
      .chan_cmd (chan_cmd[n]),
      .cmd_word (cmd_word),
      .busy     (chan_busy[n]),
      .overrun  (chan_overrun[n]),
      .done     (chan_done[n]),
      .match    (chan_match[n]),
      .pattern  (chan_pattern[n])
    );
  end

  toeplitz_hash i_hash (
    .clk       (clk),
    .rst       (rst),
    .hash_op   (hash_op),
    .hash_word (hash_word),
    .hash_out  (hash_out)
  );

endmodule

// ==== accel_properties.sv ====
`include "accel_consts.svh"

module accel_properties (
  input logic                 clk,
  input logic                 rst,
  input logic                 io_en,
  input logic                 io_wen,
  input logic                 io_rd_valid,
  input accel_pkg::chan_cmd_e chan_cmd [`ACCEL_CHAN_COUNT]
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [`ACCEL_CHAN_COUNT-1:0] cmd_active;

  always_comb begin
    for (int i = 0; i < `ACCEL_CHAN_COUNT; i++) begin
      cmd_active[i] = (chan_cmd[i] != accel_pkg::CMD_NONE);
    end
  end

  rd_valid_low_in_reset: assert property (
    @(posedge clk) rst |=> !io_rd_valid
  ) else $error("io_rd_valid is high during reset");

  // one cycle normally, two when the read meets a hash opcode.
  rd_valid_follows_read: assert property (
    @(posedge clk) disable iff (rst)
    (io_en && !io_wen) |-> ##[1:2] io_rd_valid
  ) else $error("read request without io_rd_valid within two cycles");

  one_chan_cmd: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(cmd_active)
  ) else $error("more than one channel command active in a cycle");

endmodule

bind accel_regs accel_properties i_props (
  .clk         (clk),
  .rst         (rst),
  .io_en       (io_en),
  .io_wen      (io_wen),
  .io_rd_valid (io_rd_valid),
  .chan_cmd    (chan_cmd)
);

// ==== accel_tb.sv ====
`include "accel_consts.svh"

module accel_tb;
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [1:0] {
    OP_WR,
    OP_RD,
    OP_IDLE // polls a channel status word until busy drops.
  } op_e;

  typedef struct packed {
    op_e                             op;
    logic [`ACCEL_IO_ADDR_WIDTH-1:0] addr;
    logic [`ACCEL_IO_DATA_WIDTH-1:0] data;
    logic [`ACCEL_IO_DATA_WIDTH-1:0] exp;
    logic [`ACCEL_IO_DATA_WIDTH-1:0] mask;
  } row_t;

  localparam logic [319:0] KEY = `ACCEL_HASH_KEY;
  localparam int TIMEOUT = 50;

  logic                            clk;
  logic                            rst;
  logic                            io_en;
  logic                            io_wen;
  logic [`ACCEL_IO_ADDR_WIDTH-1:0] io_addr;
  logic [`ACCEL_IO_DATA_WIDTH-1:0] io_wr_data;
  logic [`ACCEL_IO_DATA_WIDTH-1:0] io_rd_data;
  logic                            io_rd_valid;

  row_t        rows[$];
  logic [31:0] model_hash;
  int          model_offset; // byte position of the next hashed byte.
  int          pass_count;
  int          fail_count;

  accel_top i_dut (
    .clk         (clk),
    .rst         (rst),
    .io_en       (io_en),
    .io_wen      (io_wen),
    .io_addr     (io_addr),
    .io_wr_data  (io_wr_data),
    .io_rd_data  (io_rd_data),
    .io_rd_valid (io_rd_valid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic add_row(input op_e op, input logic [8:0] addr, input logic [31:0] data,
                         input logic [31:0] exp, input logic [31:0] mask);
    row_t r;
    r.op   = op;
    r.addr = addr;
    r.data = data;
    r.exp  = exp;
    r.mask = mask;
    rows.push_back(r);
  endtask

  task automatic wr(input logic [8:0] addr, input logic [31:0] data);
    add_row(OP_WR, addr, data, '0, '0);
  endtask

  task automatic rd(input logic [8:0] addr, input logic [31:0] exp, input logic [31:0] mask);
    add_row(OP_RD, addr, '0, exp, mask);
  endtask

  task automatic wait_idle(input int ch);
    add_row(OP_IDLE, 9'(ch * 16), '0, '0, '0);
  endtask

  // one input byte at global byte index idx, per the Toeplitz key rule.
  function automatic logic [31:0] hash_byte(input logic [31:0] h, input logic [7:0] b,
                                            input int idx);
    logic [319:0] win;
    logic [31:0]  r;
    r = h;
    if (idx < `ACCEL_HASH_MAX_BYTES) begin
      for (int k = 0; k < 8; k++) begin
        if (b[7 - k]) begin
          win = KEY << (idx * 8 + k);
          r   = r ^ win[319:288];
        end
      end
    end
    return r;
  endfunction

  task automatic hash_clear();
    model_hash   = '0;
    model_offset = 0;
    wr(9'h100, 32'h0);
  endtask

  task automatic hash_add(input int nbytes);
    logic [31:0] w;
    logic [8:0]  addr;
    w    = $urandom();
    addr = (nbytes == 1) ? 9'h104 : ((nbytes == 2) ? 9'h108 : 9'h10C);
    for (int i = 0; i < nbytes; i++) begin
      model_hash = hash_byte(model_hash, w[31 - 8 * i -: 8], model_offset + i);
    end
    model_offset += nbytes;
    wr(addr, w);
  endtask

  task automatic bus_read(input logic [8:0] addr, output logic [31:0] data, output bit ok);
    int cycles;
    @(negedge clk);
    io_en   = 1'b1;
    io_wen  = 1'b0;
    io_addr = addr;
    ok      = 1'b0;
    data    = '0;
    cycles  = 0;
    while (!ok && cycles < TIMEOUT) begin
      @(negedge clk);
      io_en = 1'b0;
      cycles++;
      if (io_rd_valid) begin
        ok   = 1'b1;
        data = io_rd_data;
      end
    end
  endtask

  task automatic apply_row(input int n, input row_t r);
    logic [31:0] data;
    bit          ok;
    bit          busy;
    int          polls;
    case (r.op)
      OP_WR: begin
        @(negedge clk);
        io_en      = 1'b1;
        io_wen     = 1'b1;
        io_addr    = r.addr;
        io_wr_data = r.data;
        $display("row %0d: write 0x%03h <= 0x%08h", n, r.addr, r.data);
      end
      OP_RD: begin
        bus_read(r.addr, data, ok);
        assert (ok) else begin
          $display("row %0d: no read response from 0x%03h before the timeout", n, r.addr);
          fail_count++;
        end
        if (ok) begin
          assert ((data & r.mask) == (r.exp & r.mask)) begin
            $display("row %0d: read 0x%03h = 0x%08h ok", n, r.addr, data);
            pass_count++;
          end else begin
            $display("MISMATCH at %0t: row %0d read 0x%03h got 0x%08h expected 0x%08h",
                     $time, n, r.addr, data, r.exp);
            fail_count++;
          end
        end
      end
      default: begin
        @(negedge clk);
        io_en = 1'b0; // lets the last command pulse reach the channel first.
        ok    = 1'b1;
        busy  = 1'b1;
        polls = 0;
        while (ok && busy && polls < TIMEOUT) begin
          bus_read(r.addr, data, ok);
          busy = data[1];
          polls++;
        end
        assert (ok && !busy) begin
          $display("row %0d: channel at 0x%03h idle", n, r.addr);
          pass_count++;
        end else begin
          $display("row %0d: channel at 0x%03h did not become idle in time", n, r.addr);
          fail_count++;
        end
      end
    endcase
  endtask

  initial begin
    rst          = 1'b1;
    io_en        = 1'b0;
    io_wen       = 1'b0;
    io_addr      = '0;
    io_wr_data   = '0;
    pass_count   = 0;
    fail_count   = 0;
    model_hash   = '0;
    model_offset = 0;
    void'($urandom(62));

    for (int ch = 0; ch < 4; ch++) begin
      rd(9'(ch * 16), 32'h0, 32'h306);
    end
    rd(9'h080, 32'h0, 32'hF);
    rd(9'h100, 32'h0, 32'hFFFFFFFF);

    // channel 0 finds DEADBEEF split over two words, channel 1 sees no match.
    wr(9'h000, 32'h1);
    wr(9'h004, 32'hDEADBEEF);
    wait_idle(0);
    rd(9'h004, 32'hDEADBEEF, 32'hFFFFFFFF);
    wr(9'h008, 32'h1122DEAD);
    wait_idle(0);
    wr(9'h00C, 32'hBEEF3344);
    wait_idle(0);
    rd(9'h000, 32'h300, 32'h306);
    wr(9'h010, 32'h1);
    wr(9'h014, 32'h55667788);
    wr(9'h01C, 32'hDEADBEEF);
    wait_idle(1);
    rd(9'h010, 32'h100, 32'h306);
    rd(9'h080, 32'h3, 32'hF);

    wr(9'h020, 32'h11); // init and stop together, init takes priority.
    wait_idle(2);
    rd(9'h020, 32'h0, 32'h306);
    wr(9'h024, 32'hA5A5A5A5);
    wr(9'h02C, 32'hA5A5A5A5);
    wait_idle(2);
    rd(9'h020, 32'h300, 32'h306);
    wr(9'h020, 32'h1);
    wait_idle(2);
    rd(9'h020, 32'h0, 32'h306);
    wr(9'h020, 32'h10);
    wait_idle(2);
    rd(9'h020, 32'h100, 32'h306);
    wr(9'h020, 32'h1);
    wr(9'h028, 32'hA5A5A5A5); // a plain data word, so channel 2 matches without done.
    wait_idle(2);
    rd(9'h020, 32'h200, 32'h306);

    // second data word lands while busy, so SCAN_FEED never sees the pattern.
    wr(9'h030, 32'h1);
    wr(9'h034, 32'hCAFEBABE);
    wr(9'h038, 32'h00000000);
    wr(9'h03C, 32'hCAFEBABE);
    wait_idle(3);
    rd(9'h030, 32'h004, 32'h306);
    rd(9'h080, 32'h7, 32'hF);

    hash_clear();
    rd(9'h100, model_hash, 32'hFFFFFFFF);
    hash_add(1);
    rd(9'h100, model_hash, 32'hFFFFFFFF);
    hash_add(2);
    rd(9'h104, model_hash, 32'hFFFFFFFF);
    hash_add(4);
    rd(9'h10C, model_hash, 32'hFFFFFFFF);
    for (int i = 0; i < 8; i++) begin
      hash_add(4);
    end
    rd(9'h110, model_hash, 32'hFFFFFFFF);
    hash_add(4);
    rd(9'h108, model_hash, 32'hFFFFFFFF);
    hash_add(1);
    rd(9'h1FC, model_hash, 32'hFFFFFFFF);

    repeat (16) @(negedge clk);
    rst = 1'b0;

    foreach (rows[n]) begin
      apply_row(n, rows[n]);
    end
    @(negedge clk);
    io_en = 1'b0;

    $display("checks: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+.
accel_pkg.sv
scan_channel.sv
toeplitz_hash.sv
accel_regs.sv
accel_top.sv
accel_properties.sv
accel_tb.sv

// ==== Makefile ====
# Verilator build and run of the packet-inspection accelerator testbench.

TOP := accel_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, fail on a failing result"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -o sim
	./obj_dir/sim > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "RESULT: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" sim.log; then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
